//--- Bender.yml
package:
  name: vreg_unpack

sources:
  # RTL in compile order
  - source/vreg_unpack_pkg.sv
  - source/unpack_stage_if.sv
  - source/unpack_pipe.sv
  - source/vreg_read_ctrl.sv
  - source/operand_extract.sv
  - source/mask_extract.sv
  - source/vreg_unpack_top.sv

  # testbench and bound checker
  - target: test
    files:
      - verif/vreg_unpack_checker.sv
      - verif/tb_vreg_unpack.sv

//--- flist.f
source/vreg_unpack_pkg.sv
source/unpack_stage_if.sv
source/unpack_pipe.sv
source/vreg_read_ctrl.sv
source/operand_extract.sv
source/mask_extract.sv
source/vreg_unpack_top.sv
verif/vreg_unpack_checker.sv
verif/tb_vreg_unpack.sv

//--- source/mask_extract.sv
// Mask conversion from one bit per element to one bit per byte.
// Combinational on the stage 1 mask buffer, registered by the pipe.

`timescale 1ns/10ps

module mask_extract #(
    parameter int unsigned VREG_W = vreg_unpack_pkg::DEF_VREG_W
) (
    unpack_stage_if.m_ext stg
);

    localparam int unsigned W      = vreg_unpack_pkg::DEF_VREG_W;
    localparam int unsigned MASK_W = VREG_W / 8; // bytes per register

    logic [W-1:0]              src_raw;
    vreg_unpack_pkg::op_word_u src;

    always_comb begin
        src_raw             = '0;
        src_raw[MASK_W-1:0] = stg.mask_buf[MASK_W-1:0]; // only the low element bits matter
        src                 = src_raw;
        for (int k = 0; k < MASK_W; k++) begin
            // element k/1, k/2 or k/4 covers byte k
            unique case (stg.eew[1])
                vreg_unpack_pkg::VSEW_8:  stg.mask_bytes[k] = src.b[k/8][k%8];
                vreg_unpack_pkg::VSEW_16: stg.mask_bytes[k] = src.b[k/16][(k/2)%8];
                vreg_unpack_pkg::VSEW_32: stg.mask_bytes[k] = src.b[k/32][(k/4)%8];
                default:                  stg.mask_bytes[k] = 1'b0;
            endcase
        end
    end

endmodule

//--- source/operand_extract.sv
// Operand A extraction in the last stage.
// Widens a narrow operand, splats a scalar or passes the full word on.
// Only widths up to the default operand word are supported.

`timescale 1ns/10ps

module operand_extract #(
    parameter int unsigned VREG_W = vreg_unpack_pkg::DEF_VREG_W
) (
    unpack_stage_if.a_ext stg,
    output logic [VREG_W-1:0] a_data_o
);

    localparam int unsigned W = vreg_unpack_pkg::DEF_VREG_W;

    if ((VREG_W % 32) != 0 || VREG_W > W) begin : g_width_check
        $fatal(1, "VREG_W of %0d is not a multiple of 32 up to %0d", VREG_W, W);
    end

    logic [W-1:0]              src_raw;
    logic [W-1:0]              res_raw;
    vreg_unpack_pkg::op_word_u src;
    vreg_unpack_pkg::op_word_u wide;
    vreg_unpack_pkg::op_word_u splat;
    vreg_unpack_pkg::op_word_u res;

    always_comb begin
        src_raw             = '0;
        src_raw[VREG_W-1:0] = stg.a_buf;
        src                 = src_raw;
    end

    // lower half widened element by element
    always_comb begin
        wide = src;
        unique case (stg.eew_2)
            vreg_unpack_pkg::VSEW_16: begin
                for (int j = 0; j < W / 16; j++) begin
                    wide.h[j] = {{8{stg.a_sigext_2 & src.b[j][7]}}, src.b[j]};
                end
            end
            vreg_unpack_pkg::VSEW_32: begin
                for (int j = 0; j < W / 32; j++) begin
                    wide.w[j] = {{16{stg.a_sigext_2 & src.h[j][15]}}, src.h[j]};
                end
            end
            default: ; // no narrow form at eew 8
        endcase
    end

    always_comb begin
        splat = '0;
        unique case (stg.eew_2)
            vreg_unpack_pkg::VSEW_8:  for (int j = 0; j < W / 8; j++)  splat.b[j] = stg.xval_2[7:0];
            vreg_unpack_pkg::VSEW_16: for (int j = 0; j < W / 16; j++) splat.h[j] = stg.xval_2[15:0];
            vreg_unpack_pkg::VSEW_32: for (int j = 0; j < W / 32; j++) splat.w[j] = stg.xval_2;
            default: ;
        endcase
    end

    always_comb begin
        if (!stg.a_vreg_2) begin
            res = splat;            // scalar operand
        end else if (stg.a_narrow_2) begin
            res = wide;
        end else begin
            res = src;
        end
        res_raw  = res;
        a_data_o = res_raw[VREG_W-1:0];
    end

endmodule

//--- source/unpack_pipe.sv
// Stage registers of the unpack pipeline: valid bits, ready chain and stage state.
// Operand buffers are filled from the read ports as items advance.
// Three stages; stage 0 is the input itself and is not registered.

`timescale 1ns/10ps

module unpack_pipe #(
    parameter int unsigned VREG_W = vreg_unpack_pkg::DEF_VREG_W,
    parameter int unsigned CTRL_W = 8
) (
    input  logic                               clk_i,
    input  logic                               async_rst_ni,

    // input side
    input  logic                               in_valid_i,
    output logic                               in_ready_o,
    input  logic [CTRL_W-1:0]                  in_ctrl_i,
    input  vreg_unpack_pkg::vsew_e             in_eew_i,
    input  vreg_unpack_pkg::vaddr_t            in_a_vaddr_i,
    input  logic                               in_a_vreg_i,
    input  logic                               in_a_narrow_i,
    input  logic                               in_a_sigext_i,
    input  logic [vreg_unpack_pkg::XVAL_W-1:0] in_a_xval_i,
    input  logic                               in_mask_en_i,

    // register file read data
    input  logic [VREG_W-1:0]                  vreg_a_rd_data_i,
    input  logic [VREG_W-1:0]                  vreg_m_rd_data_i,

    // output side
    output logic                               out_valid_o,
    input  logic                               out_ready_i,
    output logic [CTRL_W-1:0]                  out_ctrl_o,
    output logic [VREG_W/8-1:0]                out_mask_o,

    output logic                               stage_active_o,

    unpack_stage_if.pipe                       stg
);

    localparam int unsigned LAST_STAGE = 2;

    logic [LAST_STAGE:0] stage_ready;
    logic [LAST_STAGE:1] valid_q;

    // stage 1 state
    vreg_unpack_pkg::vsew_e             eew_1_q;
    vreg_unpack_pkg::vaddr_t            a_vaddr_1_q;
    logic                               a_vreg_1_q;
    logic                               a_narrow_1_q;
    logic                               a_sigext_1_q;
    logic [vreg_unpack_pkg::XVAL_W-1:0] xval_1_q;

    logic [VREG_W/8-1:0] mask_2_q; // byte mask of stage 2

    assign stg.stage_valid = {valid_q, in_valid_i};
    assign stg.eew         = {eew_1_q, in_eew_i};
    assign stg.a_vaddr     = {a_vaddr_1_q, in_a_vaddr_i};
    assign stg.a_vreg      = {a_vreg_1_q, in_a_vreg_i};
    assign stg.a_narrow    = {a_narrow_1_q, in_a_narrow_i};
    assign stg.a_sigext    = {a_sigext_1_q, in_a_sigext_i};
    assign stg.mask_en     = in_mask_en_i;

    // no stage stalls on its own, so a stage may move whenever the output drains
    // or a hole sits anywhere between it and the output
    always_comb begin
        for (int i = 0; i <= LAST_STAGE; i++) begin
            stage_ready[i] = out_ready_i;
            for (int j = i; j <= LAST_STAGE; j++) begin
                if (!stg.stage_valid[j]) begin
                    stage_ready[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= '0;
        end else begin
            if (stage_ready[1]) begin
                valid_q[1] <= in_valid_i;
            end
            if (stage_ready[2]) begin
                valid_q[2] <= valid_q[1];
            end
        end
    end

    // stage 1, mask read from port M in stage 0
    always_ff @(posedge clk_i) begin
        if (stage_ready[1]) begin
            eew_1_q      <= in_eew_i;
            a_vaddr_1_q  <= in_a_vaddr_i;
            a_vreg_1_q   <= in_a_vreg_i;
            a_narrow_1_q <= in_a_narrow_i;
            a_sigext_1_q <= in_a_sigext_i;
            xval_1_q     <= in_a_xval_i;
            stg.ctrl_1   <= in_ctrl_i;
            stg.mask_buf <= vreg_m_rd_data_i;
        end
    end

    // stage 2, operand A read from port A in stage 1
    always_ff @(posedge clk_i) begin
        if (stage_ready[2]) begin
            stg.eew_2      <= eew_1_q;
            stg.a_vreg_2   <= a_vreg_1_q;
            stg.a_narrow_2 <= a_narrow_1_q;
            stg.a_sigext_2 <= a_sigext_1_q;
            stg.xval_2     <= xval_1_q;
            stg.ctrl_2     <= stg.ctrl_1;
            stg.a_buf      <= vreg_a_rd_data_i;
            mask_2_q       <= stg.mask_bytes; // already expanded
        end
    end

    assign in_ready_o     = stage_ready[0];
    assign out_valid_o    = valid_q[LAST_STAGE];
    assign out_ctrl_o     = stg.ctrl_2;
    assign out_mask_o     = mask_2_q;
    assign stage_active_o = |stg.stage_valid;

endmodule

//--- source/unpack_stage_if.sv
// Stage valids and stage state of the unpack pipeline.
// Shared by the pipe registers, the read control and both extractors.

`timescale 1ns/10ps

interface unpack_stage_if #(
    parameter int unsigned VREG_W = vreg_unpack_pkg::DEF_VREG_W,
    parameter int unsigned CTRL_W = 8
);

    logic [2:0] stage_valid; // stage 0 is the live input

    // stages 0 and 1
    vreg_unpack_pkg::vsew_e  [1:0] eew;
    vreg_unpack_pkg::vaddr_t [1:0] a_vaddr;
    logic                    [1:0] a_vreg;
    logic                    [1:0] a_narrow;
    logic                    [1:0] a_sigext;
    logic                          mask_en;   // stage 0 only
    logic [CTRL_W-1:0]             ctrl_1;
    logic [VREG_W-1:0]             mask_buf;  // v0 as read in stage 0

    // stage 2
    logic [CTRL_W-1:0]                   ctrl_2;
    logic [VREG_W-1:0]                   a_buf;
    vreg_unpack_pkg::vsew_e              eew_2;
    logic [vreg_unpack_pkg::XVAL_W-1:0]  xval_2;
    logic                                a_vreg_2;
    logic                                a_narrow_2;
    logic                                a_sigext_2;

    logic [VREG_W/8-1:0] mask_bytes; // byte mask from mask_buf

    modport pipe (
        output stage_valid, eew, a_vaddr, a_vreg, a_narrow, a_sigext, mask_en, ctrl_1,
        output mask_buf, ctrl_2, a_buf, eew_2, xval_2, a_vreg_2, a_narrow_2, a_sigext_2,
        input  mask_bytes
    );

    modport rd (input stage_valid, a_vaddr, a_vreg, mask_en);

    modport a_ext (input a_buf, eew_2, xval_2, a_vreg_2, a_narrow_2, a_sigext_2);

    modport m_ext (input mask_buf, eew, output mask_bytes);

endinterface

//--- source/vreg_read_ctrl.sv
// Read port A addressing and the pending-read mask over all vector registers.
// Purely combinational on the stage state.

`timescale 1ns/10ps

module vreg_read_ctrl (
    unpack_stage_if.rd                    stg,
    output vreg_unpack_pkg::vaddr_t       vreg_a_rd_addr_o,
    output vreg_unpack_pkg::vreg_mask_t   pending_reads_o
);

    // stage in which each operand is read from the register file
    localparam int unsigned A_LOAD_STAGE = 1;
    localparam int unsigned M_LOAD_STAGE = 0;

    localparam vreg_unpack_pkg::vaddr_t MASK_VREG = '0; // mask always lives in v0

    assign vreg_a_rd_addr_o = stg.a_vaddr[A_LOAD_STAGE];

    // a register stays pending until the stage that loads it has been passed
    always_comb begin
        pending_reads_o = '0;
        for (int i = 0; i <= A_LOAD_STAGE; i++) begin
            if (stg.stage_valid[i] && stg.a_vreg[i]) begin
                pending_reads_o[stg.a_vaddr[i]] = 1'b1;
            end
        end
        if (stg.stage_valid[M_LOAD_STAGE] && stg.mask_en) begin
            pending_reads_o[MASK_VREG] = 1'b1;
        end
    end

endmodule

//--- source/vreg_unpack_pkg.sv
// Shared types for the operand unpack pipeline.
// Referenced by scoped name from the RTL and the testbench.

package vreg_unpack_pkg;

    // element width of the current instruction
    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

    // vector register addressing
    localparam int unsigned VADDR_W = 5;
    typedef logic [VADDR_W-1:0] vaddr_t;

    localparam int unsigned VREG_CNT = 32;
    typedef logic [VREG_CNT-1:0] vreg_mask_t; // one bit per vector register

    // default read port and operand width
    localparam int unsigned DEF_VREG_W = 64;

    // scalar (X register) value width
    localparam int unsigned XVAL_W = 32;

    // one operand word, seen as bytes, halfwords or words
    typedef union packed {
        logic [DEF_VREG_W/8-1:0][7:0]   b;
        logic [DEF_VREG_W/16-1:0][15:0] h;
        logic [DEF_VREG_W/32-1:0][31:0] w;
    } op_word_u;

endpackage

//--- source/vreg_unpack_top.sv
// Top level of the operand unpack pipeline.
// Items go in on a valid/ready handshake and come out two stages later.

`timescale 1ns/10ps

module vreg_unpack_top #(
    parameter int unsigned VREG_W = vreg_unpack_pkg::DEF_VREG_W,
    parameter int unsigned CTRL_W = 8
) (
    input  logic                               clk_i,
    input  logic                               async_rst_ni,

    input  logic                               in_valid_i,
    output logic                               in_ready_o,
    input  logic [CTRL_W-1:0]                  in_ctrl_i,
    input  vreg_unpack_pkg::vsew_e             in_eew_i,
    input  vreg_unpack_pkg::vaddr_t            in_a_vaddr_i,
    input  logic                               in_a_vreg_i,
    input  logic                               in_a_narrow_i,
    input  logic                               in_a_sigext_i,
    input  logic [vreg_unpack_pkg::XVAL_W-1:0] in_a_xval_i,
    input  logic                               in_mask_en_i,

    // register file, port M always reads v0
    output vreg_unpack_pkg::vaddr_t            vreg_a_rd_addr_o,
    input  logic [VREG_W-1:0]                  vreg_a_rd_data_i,
    input  logic [VREG_W-1:0]                  vreg_m_rd_data_i,

    output logic                               out_valid_o,
    input  logic                               out_ready_i,
    output logic [CTRL_W-1:0]                  out_ctrl_o,
    output logic [VREG_W-1:0]                  out_a_data_o,
    output logic [VREG_W/8-1:0]                out_mask_o,

    output vreg_unpack_pkg::vreg_mask_t        pending_reads_o,
    output logic                               stage_active_o
);

    unpack_stage_if #(.VREG_W(VREG_W), .CTRL_W(CTRL_W)) stg_if ();

    unpack_pipe #(.VREG_W(VREG_W), .CTRL_W(CTRL_W)) u_pipe (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .in_ctrl_i        (in_ctrl_i),
        .in_eew_i         (in_eew_i),
        .in_a_vaddr_i     (in_a_vaddr_i),
        .in_a_vreg_i      (in_a_vreg_i),
        .in_a_narrow_i    (in_a_narrow_i),
        .in_a_sigext_i    (in_a_sigext_i),
        .in_a_xval_i      (in_a_xval_i),
        .in_mask_en_i     (in_mask_en_i),
        .vreg_a_rd_data_i (vreg_a_rd_data_i),
        .vreg_m_rd_data_i (vreg_m_rd_data_i),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_ctrl_o       (out_ctrl_o),
        .out_mask_o       (out_mask_o),
        .stage_active_o   (stage_active_o),
        .stg              (stg_if.pipe)
    );

    vreg_read_ctrl u_rd (
        .stg              (stg_if.rd),
        .vreg_a_rd_addr_o (vreg_a_rd_addr_o),
        .pending_reads_o  (pending_reads_o)
    );

    operand_extract #(.VREG_W(VREG_W)) u_a_ext (
        .stg      (stg_if.a_ext),
        .a_data_o (out_a_data_o)
    );

    mask_extract #(.VREG_W(VREG_W)) u_m_ext (
        .stg (stg_if.m_ext)
    );

endmodule

//--- verif/tb_vreg_unpack.sv
// Testbench for the operand unpack pipeline.
// Drives random items against a random register file and checks them from a queue.

`timescale 1ns/10ps

module tb_vreg_unpack;

    localparam int unsigned VREG_W     = 64;
    localparam int unsigned CTRL_W     = 8;
    localparam int unsigned N_ITEMS    = 400;
    localparam int unsigned CLK_PERIOD = 8;

    typedef struct packed {
        logic [CTRL_W-1:0]   ctrl;
        logic [VREG_W-1:0]   a_data;
        logic [VREG_W/8-1:0] mask;
    } exp_item_t;

    logic clk_i;
    logic async_rst_ni;

    logic                               in_valid;
    logic                               in_ready;
    logic [CTRL_W-1:0]                  in_ctrl;
    vreg_unpack_pkg::vsew_e             in_eew;
    vreg_unpack_pkg::vaddr_t            in_a_vaddr;
    logic                               in_a_vreg;
    logic                               in_a_narrow;
    logic                               in_a_sigext;
    logic [vreg_unpack_pkg::XVAL_W-1:0] in_a_xval;
    logic                               in_mask_en;
    vreg_unpack_pkg::vaddr_t            rd_addr;
    logic [VREG_W-1:0]                  rd_a_data;
    logic [VREG_W-1:0]                  rd_m_data;
    logic                               out_valid;
    logic                               out_ready;
    logic [CTRL_W-1:0]                  out_ctrl;
    logic [VREG_W-1:0]                  out_a_data;
    logic [VREG_W/8-1:0]                out_mask;
    vreg_unpack_pkg::vreg_mask_t        pending_reads;
    logic                               stage_active;

    logic [VREG_W-1:0] rf [vreg_unpack_pkg::VREG_CNT]; // register file model
    logic [31:0]       lcg_state = 32'hd782;
    exp_item_t         exp_q [$];
    int unsigned       acc_cnt = 0;
    int unsigned       out_cnt = 0;
    logic              in_fire = 1'b0;

    vreg_unpack_top #(.VREG_W(VREG_W), .CTRL_W(CTRL_W)) dut_i (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .in_valid_i       (in_valid),
        .in_ready_o       (in_ready),
        .in_ctrl_i        (in_ctrl),
        .in_eew_i         (in_eew),
        .in_a_vaddr_i     (in_a_vaddr),
        .in_a_vreg_i      (in_a_vreg),
        .in_a_narrow_i    (in_a_narrow),
        .in_a_sigext_i    (in_a_sigext),
        .in_a_xval_i      (in_a_xval),
        .in_mask_en_i     (in_mask_en),
        .vreg_a_rd_addr_o (rd_addr),
        .vreg_a_rd_data_i (rd_a_data),
        .vreg_m_rd_data_i (rd_m_data),
        .out_valid_o      (out_valid),
        .out_ready_i      (out_ready),
        .out_ctrl_o       (out_ctrl),
        .out_a_data_o     (out_a_data),
        .out_mask_o       (out_mask),
        .pending_reads_o  (pending_reads),
        .stage_active_o   (stage_active)
    );

    // port A follows the read address and port M always reads v0
    assign rd_a_data = rf[rd_addr];
    assign rd_m_data = rf[0];

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected operand A from the live input fields
    function automatic logic [VREG_W-1:0] expected_operand();
        logic [VREG_W-1:0] word;
        logic [VREG_W-1:0] res;
        int                ew;
        int                hw;
        word = rf[in_a_vaddr];
        ew   = 8 << int'(in_eew);
        hw   = ew / 2;
        res  = word;
        for (int e = 0; e < VREG_W / ew; e++) begin
            for (int b = 0; b < ew; b++) begin
                if (!in_a_vreg) begin
                    res[e*ew+b] = in_a_xval[b]; // scalar splat
                end else if (in_a_narrow) begin
                    res[e*ew+b] = (b < hw) ? word[e*hw+b] : (in_a_sigext & word[e*hw+hw-1]);
                end
            end
        end
        return res;
    endfunction

    function automatic logic [VREG_W/8-1:0] expected_mask();
        logic [VREG_W/8-1:0] res;
        int                  bytes_per_elem;
        bytes_per_elem = 1 << int'(in_eew);
        for (int k = 0; k < VREG_W / 8; k++) begin
            res[k] = rf[0][k / bytes_per_elem];
        end
        return res;
    endfunction

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_field(input string name, input logic [VREG_W-1:0] exp_val,
                               input logic [VREG_W-1:0] act_val);
        assert (act_val == exp_val) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_val, act_val);
            fail_run();
        end
    endtask

    task automatic drive_item();
        logic [31:0] r;
        logic        narrow;
        r      = lcg_next();
        narrow = r[29] && (r[31:30] != 2'b00);
        in_valid    <= 1'b1;
        in_a_vreg   <= r[31:30] != 2'b00;
        in_a_narrow <= narrow;
        if (narrow) begin
            in_eew <= r[28] ? vreg_unpack_pkg::VSEW_32 : vreg_unpack_pkg::VSEW_16;
        end else if (r[27:26] == 2'b11) begin
            in_eew <= vreg_unpack_pkg::VSEW_8;
        end else begin
            in_eew <= vreg_unpack_pkg::vsew_e'(r[27:26]);
        end
        in_a_sigext <= r[25];
        in_mask_en  <= r[24];
        in_a_vaddr  <= r[23:19];
        in_ctrl     <= r[18:11];
        in_a_xval   <= lcg_next();
    endtask

    // inputs and outputs are settled at the falling edge
    always @(negedge clk_i) begin
        exp_item_t exp;
        if (dut_i.u_checker.err_cnt != 0) begin
            $display("a protocol assertion in the checker failed at %0t", $time);
            fail_run();
        end
        in_fire = in_valid && in_ready;
        if (in_fire) begin
            exp_q.push_back('{ctrl: in_ctrl, a_data: expected_operand(), mask: expected_mask()});
            acc_cnt++;
        end
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output item at %0t with no item pending", $time);
                fail_run();
            end
            exp = exp_q.pop_front();
            check_field("out_ctrl_o", VREG_W'(exp.ctrl), VREG_W'(out_ctrl));
            check_field("out_a_data_o", exp.a_data, out_a_data);
            check_field("out_mask_o", VREG_W'(exp.mask), VREG_W'(out_mask));
            out_cnt++;
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        async_rst_ni = 1'b0;
        in_valid     = 1'b0;
        in_ctrl      = '0;
        in_eew       = vreg_unpack_pkg::VSEW_8;
        in_a_vaddr   = '0;
        in_a_vreg    = 1'b0;
        in_a_narrow  = 1'b0;
        in_a_sigext  = 1'b0;
        in_a_xval    = '0;
        in_mask_en   = 1'b0;
        out_ready    = 1'b0;
        for (int i = 0; i < vreg_unpack_pkg::VREG_CNT; i++) begin
            rf[i][63:32] = lcg_next();
            rf[i][31:0]  = lcg_next();
        end
        repeat (3) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(posedge clk_i);
        while (acc_cnt < N_ITEMS) begin
            @(posedge clk_i);
            r = lcg_next();
            out_ready <= r[31:30] != 2'b00;
            if (!in_valid || in_fire) begin   // hold an offered item until taken
                if (acc_cnt < N_ITEMS && r[29:28] != 2'b00) begin
                    drive_item();
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
        @(posedge clk_i);
        out_ready <= 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (4) @(negedge clk_i);
        // nothing left in flight, so no stage is valid and no read is pending
        if (!stage_active && pending_reads == '0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("[FAIL] %0t stage_active_o expected 0 actual %b pending_reads_o expected %h actual %h",
                     $time, stage_active, 32'h0, pending_reads);
            $display("Simulation failed");
            $fatal(1, "pipe not idle after the last item");
        end
    end

    initial begin : watchdog
        #(N_ITEMS * 20 * CLK_PERIOD);
        $display("run timed out with %0d of %0d items delivered", out_cnt, N_ITEMS);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verif/vreg_unpack_checker.sv
// Protocol assertions for the operand unpack pipeline.
// Bound to vreg_unpack_top, failures show up as assertion errors only.

`timescale 1ns/10ps

module vreg_unpack_checker #(
    parameter int unsigned VREG_W = vreg_unpack_pkg::DEF_VREG_W,
    parameter int unsigned CTRL_W = 8
) (
    input logic                        clk_i,
    input logic                        async_rst_ni,
    input logic                        in_valid_i,
    input logic                        in_ready_i,
    input vreg_unpack_pkg::vaddr_t     in_a_vaddr_i,
    input logic                        in_a_vreg_i,
    input logic                        in_mask_en_i,
    input logic                        out_valid_i,
    input logic                        out_ready_i,
    input logic [CTRL_W-1:0]           out_ctrl_i,
    input logic [VREG_W-1:0]           out_a_data_i,
    input logic [VREG_W/8-1:0]         out_mask_i,
    input vreg_unpack_pkg::vreg_mask_t pending_reads_i,
    input logic                        stage_active_i,
    input logic [2:0]                  stage_valid_i
);

    int unsigned err_cnt = 0; // polled by the testbench

    // a stalled output must not move
    hold_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_ctrl_i)
            && $stable(out_a_data_i) && $stable(out_mask_i)))
        else begin
            $error("output changed while stalled");
            err_cnt++;
        end

    in_reset_idle: assert property (@(posedge clk_i)
        !async_rst_ni |-> (!out_valid_i && pending_reads_i == '0))
        else begin
            $error("output valid or pending reads set during reset");
            err_cnt++;
        end

    after_reset_idle: assert property (@(posedge clk_i)
        $rose(async_rst_ni) |-> (!out_valid_i && pending_reads_i == '0))
        else begin
            $error("output valid or pending reads set right after reset");
            err_cnt++;
        end

    // empty pipe, no back-pressure: two cycles to the output
    empty_latency: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (in_valid_i && in_ready_i && out_ready_i && stage_valid_i[2:1] == 2'b00)
            |=> !out_valid_i ##1 out_valid_i)
        else begin
            $error("item did not reach the output two cycles after entry");
            err_cnt++;
        end

    a_pending: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (in_valid_i && in_ready_i && in_a_vreg_i) |-> pending_reads_i[in_a_vaddr_i])
        else begin
            $error("operand A register not marked pending on entry");
            err_cnt++;
        end

    mask_pending: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        (in_valid_i && in_mask_en_i) |-> pending_reads_i[0])
        else begin
            $error("v0 not marked pending for a masked item");
            err_cnt++;
        end

    active_flag: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i |-> stage_active_i)
        else begin
            $error("stage active flag low while output is valid");
            err_cnt++;
        end

endmodule

bind vreg_unpack_top vreg_unpack_checker #(.VREG_W(VREG_W), .CTRL_W(CTRL_W)) u_checker (
    .clk_i           (clk_i),
    .async_rst_ni    (async_rst_ni),
    .in_valid_i      (in_valid_i),
    .in_ready_i      (in_ready_o),
    .in_a_vaddr_i    (in_a_vaddr_i),
    .in_a_vreg_i     (in_a_vreg_i),
    .in_mask_en_i    (in_mask_en_i),
    .out_valid_i     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_ctrl_i      (out_ctrl_o),
    .out_a_data_i    (out_a_data_o),
    .out_mask_i      (out_mask_o),
    .pending_reads_i (pending_reads_o),
    .stage_active_i  (stage_active_o),
    .stage_valid_i   (stg_if.stage_valid)
);
